/* Bender.yml */
package:
  name: vlsu

sources:
  - logic/vlsu_pkg.sv
  - logic/vlsu_fifo.sv
  - logic/vlsu_op_queue.sv
  - logic/vlsu_mem_issue.sv
  - logic/vlsu_vrf_access.sv
  - logic/vlsu_top.sv
  - target: test
    files:
      - dv/vlsu_env_models.sv
      - dv/tb_vlsu.sv

/* dv/tb_vlsu.sv */
//////////////////////////////////////////////////
// Random operations from seed 28 against shadow memory and VRF
//////////////////////////////////////////////////
`default_nettype none

module tb_vlsu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT = 2000;

  logic clk_i, reset_i, stall;
  logic spatz_req_valid_i, spatz_req_ready_o, vlsu_rsp_valid_o;
  logic x_mem_valid_o, x_mem_ready_i, x_mem_result_valid_i, x_mem_finished_o;
  logic vrf_re_o, vrf_rvalid_i, vrf_we_o, vrf_wvalid_i;
  logic [vlsu_pkg::ELENB-1:0] vrf_wbe_o;
  vlsu_pkg::vlsu_req_t   spatz_req_i;
  vlsu_pkg::vlsu_rsp_t   vlsu_rsp_o;
  vlsu_pkg::mem_req_t    x_mem_req_o;
  vlsu_pkg::mem_result_t x_mem_result_i;
  vlsu_pkg::vreg_addr_t  vrf_raddr_o, vrf_waddr_o;
  vlsu_pkg::elen_t       vrf_rdata_i, vrf_wdata_o;

  vlsu_pkg::elen_t mem_shadow [256];
  vlsu_pkg::elen_t vrf_shadow [256];
  integer          seed = 28;
  int unsigned     checks, errors, op_count, rsp_count;

  vlsu_top DUT (.*);

  vlsu_mem_model i_mem (
    .clk_i, .reset_i, .stall_i(stall),
    .req_valid_i(x_mem_valid_o), .req_i(x_mem_req_o), .ready_o(x_mem_ready_i),
    .result_o(x_mem_result_i), .result_valid_o(x_mem_result_valid_i)
  );

  vlsu_vrf_model i_vrf (
    .clk_i, .reset_i, .stall_i(stall),
    .re_i(vrf_re_o), .raddr_i(vrf_raddr_o), .rdata_o(vrf_rdata_i), .rvalid_o(vrf_rvalid_i),
    .we_i(vrf_we_o), .waddr_i(vrf_waddr_o), .wdata_i(vrf_wdata_o), .wbe_i(vrf_wbe_o),
    .wvalid_o(vrf_wvalid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Compare tasks and the shadow model
  task automatic check_word(input vlsu_pkg::elen_t got, input vlsu_pkg::elen_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rsp(input vlsu_pkg::vlsu_rsp_t got, input vlsu_pkg::vlsu_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: response id %0d vd %0d, expected id %0d vd %0d",
               $time, got.id, got.vd, exp.id, exp.vd);
    end
  endtask

  task automatic give_up(input string why);
    $display("Timeout after %0d cycles at %0t: %s", TIMEOUT, $time, why);
    $display("TEST FAIL");
    $finish;
  endtask

  // Element i sits at byte base + i*stride in memory and at byte i*size of vd
  task automatic apply_op(input vlsu_pkg::vlsu_req_t req);
    int unsigned size, stride, addr, vbyte, vw, mb, vb;
    size   = 1 << req.vsew;
    stride = (req.op inside {vlsu_pkg::VLSE, vlsu_pkg::VSSE}) ? req.rs2 : size;
    for (int unsigned i = 0; i < req.vl; i++) begin
      addr  = req.rs1 + i * stride;
      vbyte = i * size;
      vw    = req.vd * 8 + vbyte / 4;
      for (int unsigned b = 0; b < size; b++) begin
        mb = addr % 4 + b;
        vb = vbyte % 4 + b;
        if (req.op inside {vlsu_pkg::VLE, vlsu_pkg::VLSE}) begin
          vrf_shadow[vw][8*vb +: 8] = mem_shadow[addr / 4][8*mb +: 8];
        end else begin
          mem_shadow[addr / 4][8*mb +: 8] = vrf_shadow[vw][8*vb +: 8];
        end
      end
    end
  endtask

  task automatic compare_arrays(input logic is_load);
    for (int i = 0; i < 256; i++) begin
      if (is_load) begin
        check_word(i_vrf.regs[i], vrf_shadow[i], $sformatf("VRF word %0d", i));
      end else begin
        check_word(i_mem.mem[i], mem_shadow[i], $sformatf("memory word %0d", i));
      end
    end
  endtask

  function automatic vlsu_pkg::vlsu_req_t make_req(input vlsu_pkg::vlsu_op_e op,
                                                   input vlsu_pkg::vsew_e sew);
    vlsu_pkg::vlsu_req_t req;
    int unsigned size;
    size     = 1 << sew;
    req.id   = 3'(op_count);
    req.op   = op;
    req.vsew = sew;
    req.vl   = vlsu_pkg::vl_t'(1 + $unsigned($random(seed)) % (vlsu_pkg::VLENB / size));
    req.rs1  = vlsu_pkg::elen_t'(($unsigned($random(seed)) % 512) & ~(size - 1));
    req.rs2  = vlsu_pkg::elen_t'(($unsigned($random(seed)) % 8) * size);
    req.vd   = 5'($unsigned($random(seed)) % 32);
    return req;
  endfunction

  //////////////////////////////////////////////////
  // One operation from handshake to response
  task automatic run_op(input vlsu_pkg::vlsu_req_t req);
    int unsigned n;
    logic is_load;
    vlsu_pkg::vlsu_rsp_t exp_rsp;
    exp_rsp = '{id: req.id, vd: req.vd};
    is_load = req.op inside {vlsu_pkg::VLE, vlsu_pkg::VLSE};
    spatz_req_i       <= req;
    spatz_req_valid_i <= 1'b1;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!spatz_req_ready_o && n < TIMEOUT);
    spatz_req_valid_i <= 1'b0;
    if (!spatz_req_ready_o) begin
      give_up("operation never accepted");
    end else begin
      op_count++;
      apply_op(req);
      n = 0;
      do begin
        @(posedge clk_i);
        n++;
        check_word(vlsu_pkg::elen_t'(spatz_req_ready_o), '0, "ready while operation held");
        if (x_mem_valid_o && x_mem_ready_i) begin
          check_word(vlsu_pkg::elen_t'(x_mem_req_o.size), vlsu_pkg::elen_t'(req.vsew),
                     "memory request size");
          check_word(vlsu_pkg::elen_t'(x_mem_req_o.we), vlsu_pkg::elen_t'(!is_load),
                     "memory request write enable");
        end
      end while (!vlsu_rsp_valid_o && n < TIMEOUT);
      if (!vlsu_rsp_valid_o) begin
        give_up("no response to an accepted operation");
      end else begin
        check_rsp(vlsu_rsp_o, exp_rsp);
        compare_arrays(is_load);
      end
    end
  endtask

  // Kind 0 is unit loads, 1 unit stores, 2 strided and 3 mixed
  task automatic run_test(input string name, input int unsigned kind, input int unsigned n,
                          input logic stall_en);
    int unsigned err0;
    vlsu_pkg::vlsu_op_e op;
    vlsu_pkg::vsew_e sew;
    err0 = errors;
    stall <= stall_en;
    for (int unsigned k = 0; k < n; k++) begin
      sew = vlsu_pkg::vsew_e'(kind < 2 ? k % 3 : $unsigned($random(seed)) % 3);
      case (kind)
        0:       op = vlsu_pkg::VLE;
        1:       op = vlsu_pkg::VSE;
        2:       op = ($random(seed) & 1) ? vlsu_pkg::VLSE : vlsu_pkg::VSSE;
        default: op = vlsu_pkg::vlsu_op_e'($unsigned($random(seed)) % 4);
      endcase
      run_op(make_req(op, sew));
    end
    $display("Test %s finished with %0d errors", name, errors - err0);
  endtask

  // Finished pulse must match every response
  always @(posedge clk_i) begin
    if (!reset_i && (vlsu_rsp_valid_o || x_mem_finished_o)) begin
      check_word(vlsu_pkg::elen_t'(x_mem_finished_o), vlsu_pkg::elen_t'(vlsu_rsp_valid_o),
                 "x_mem_finished_o against response");
      if (vlsu_rsp_valid_o) begin
        rsp_count++;
      end
    end
  end

  initial begin
    reset_i           = 1'b1;
    stall             = 1'b0;
    spatz_req_valid_i = 1'b0;
    spatz_req_i       = '0;
    for (int i = 0; i < 256; i++) begin
      mem_shadow[i] = (i * 32'h9E37_79B1) ^ (i << 12) ^ 32'h5A5A_0F0F;
      vrf_shadow[i] = (i * 32'h0101_0101) ^ (i << 20) ^ 32'hC3C3_1234;
      i_mem.mem[i]  = mem_shadow[i];
      i_vrf.regs[i] = vrf_shadow[i];
    end
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    // Status bits in order ready, rsp, mem valid, finished, re and we
    for (int k = 0; k < 3; k++) begin
      @(posedge clk_i);
      check_word(vlsu_pkg::elen_t'({spatz_req_ready_o, vlsu_rsp_valid_o, x_mem_valid_o,
                 x_mem_finished_o, vrf_re_o, vrf_we_o}), 32'h20, "status after reset");
    end
    $display("Test reset finished with %0d errors", errors);
    run_test("unit-stride loads", 0, 6, 1'b0);
    run_test("unit-stride stores", 1, 6, 1'b0);
    run_test("strided", 2, 10, 1'b0);
    run_test("back-pressure", 3, 30, 1'b1);
    repeat (2) @(posedge clk_i);
    check_word(rsp_count, op_count, "response count");
    $display("Checks %0d, errors %0d, operations %0d", checks, errors, op_count);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/vlsu_env_models.sv */
//////////////////////////////////////////////////
// Memory covers byte addresses 0 to 1023 only
// Random stalls and latency only while stall_i is high
//////////////////////////////////////////////////
`default_nettype none

module vlsu_mem_model (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               stall_i,
  input  wire logic               req_valid_i,
  input  wire vlsu_pkg::mem_req_t req_i,
  output logic                    ready_o,
  output vlsu_pkg::mem_result_t   result_o,
  output logic                    result_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  vlsu_pkg::elen_t mem [256];
  vlsu_pkg::elen_t rdata_q [$];
  int unsigned     due_q [$];
  int unsigned     cycle;
  int unsigned     last_due;
  int unsigned     lat;
  integer          seed = 28;

  initial begin
    ready_o        = 1'b0;
    result_valid_o = 1'b0;
    result_o       = '0;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      ready_o        <= 1'b0;
      result_valid_o <= 1'b0;
      cycle    = 0;
      last_due = 0;
      rdata_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      if (req_valid_i && ready_o) begin
        if (req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (req_i.strb[b]) begin
              mem[req_i.addr[9:2]][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
          end
        end else begin
          lat = stall_i ? 1 + $unsigned($random(seed)) % 3 : 1;
          // Results leave in request order and at most one per cycle
          last_due = (cycle + lat > last_due) ? cycle + lat : last_due + 1;
          rdata_q.push_back(mem[req_i.addr[9:2]]);
          due_q.push_back(last_due);
        end
      end
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        result_valid_o <= 1'b1;
        result_o.rdata <= rdata_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        result_valid_o <= 1'b0;
      end
      ready_o <= stall_i ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

endmodule

// VRF answers reads in the same cycle
module vlsu_vrf_model (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire logic                       stall_i,
  input  wire logic                       re_i,
  input  wire vlsu_pkg::vreg_addr_t       raddr_i,
  output vlsu_pkg::elen_t                 rdata_o,
  output logic                            rvalid_o,
  input  wire logic                       we_i,
  input  wire vlsu_pkg::vreg_addr_t       waddr_i,
  input  wire vlsu_pkg::elen_t            wdata_i,
  input  wire logic [vlsu_pkg::ELENB-1:0] wbe_i,
  output logic                            wvalid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  vlsu_pkg::elen_t regs [256];
  integer          seed = 28;

  assign rdata_o  = regs[raddr_i];
  assign rvalid_o = re_i;

  initial wvalid_o = 1'b0;

  always @(posedge clk_i) begin
    if (reset_i) begin
      wvalid_o <= 1'b0;
    end else begin
      if (we_i && wvalid_o) begin
        for (int b = 0; b < 4; b++) begin
          if (wbe_i[b]) begin
            regs[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      wvalid_o <= stall_i ? (($random(seed) & 1) != 0) : 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/vlsu_fifo.sv */
//////////////////////////////////////////////////
// Show-ahead FIFO, LOAD_DEPTH must be a power of two
// Never push when full and never pop when empty
//////////////////////////////////////////////////
`default_nettype none

module vlsu_fifo #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic push_i,
  input  wire T     data_i,
  input  wire logic pop_i,
  output T          data_o,
  output logic      empty_o,
  output logic      full_o
);

  localparam int unsigned PTR_W = $clog2(vlsu_pkg::LOAD_DEPTH);

  T               mem_q [vlsu_pkg::LOAD_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  // Pointers wrap on their own at a power-of-two depth
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PTR_W+1)'(vlsu_pkg::LOAD_DEPTH));

  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> !full_o)
    else $error("FIFO push while full");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> !empty_o)
    else $error("FIFO pop while empty");

endmodule

`default_nettype wire

/* logic/vlsu_mem_issue.sv */
//////////////////////////////////////////////////
// One element per memory access, in element order
//////////////////////////////////////////////////
`default_nettype none

module vlsu_mem_issue (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire vlsu_pkg::vlsu_cmd_t cmd_i,
  input  wire logic                cmd_start_i,
  input  wire logic                x_mem_ready_i,
  input  wire logic                lane_full_i,
  input  wire vlsu_pkg::elen_t     st_data_i,
  input  wire logic                st_empty_i,
  output logic                     x_mem_valid_o,
  output vlsu_pkg::mem_req_t       x_mem_req_o,
  output logic                     lane_push_o,
  output vlsu_pkg::lane_t          lane_o,
  output logic                     st_pop_o,
  output logic                     mem_done_o
);

  logic            active_q;
  vlsu_pkg::vl_t   cnt_q;
  vlsu_pkg::elen_t addr_q;
  vlsu_pkg::lane_t lane;
  logic            fire;
  logic            last;

  assign lane = addr_q[1:0];
  assign fire = x_mem_valid_o && x_mem_ready_i;
  assign last = (cnt_q + 1'b1) == cmd_i.num_elem;

  //////////////////////////////////////////////////
  // Element counter and running byte address
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
    end else if (cmd_start_i) begin
      active_q <= (cmd_i.num_elem != '0);
    end else if (fire && last) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_start_i) begin
      cnt_q  <= '0;
      addr_q <= cmd_i.base;
    end else if (fire) begin
      cnt_q  <= cnt_q + 1'b1;
      addr_q <= addr_q + cmd_i.stride;
    end
  end

  //////////////////////////////////////////////////
  // Request builder
  // Loads need lane credit, stores need data in the FIFO
  assign x_mem_valid_o = active_q && (cmd_i.is_load ? !lane_full_i : !st_empty_i);

  always_comb begin
    x_mem_req_o.addr  = {addr_q[31:2], 2'b00};
    x_mem_req_o.we    = !cmd_i.is_load;
    x_mem_req_o.strb  = vlsu_pkg::size_mask(cmd_i.vsew) << lane;
    x_mem_req_o.wdata = st_data_i << {lane, 3'b000};
    x_mem_req_o.size  = cmd_i.vsew;
  end

  // Lane of each load goes with it to the VRF side
  assign lane_push_o = fire && cmd_i.is_load;
  assign lane_o      = lane;
  assign st_pop_o    = fire && !cmd_i.is_load;
  assign mem_done_o  = !active_q;

  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    x_mem_valid_o && !x_mem_ready_i |=> x_mem_valid_o && $stable(x_mem_req_o))
    else $error("Memory request changed while stalled");

endmodule

`default_nettype wire

/* logic/vlsu_op_queue.sv */
//////////////////////////////////////////////////
// Holds one operation at a time, ready only while idle
//////////////////////////////////////////////////
`default_nettype none

module vlsu_op_queue (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire vlsu_pkg::vlsu_req_t  spatz_req_i,
  input  wire logic                 spatz_req_valid_i,
  input  wire logic                 mem_done_i,
  input  wire logic                 vrf_done_i,
  output logic                      spatz_req_ready_o,
  output vlsu_pkg::vlsu_cmd_t       cmd_o,
  output logic                      cmd_start_o,
  output logic                      vlsu_rsp_valid_o,
  output vlsu_pkg::vlsu_rsp_t       vlsu_rsp_o,
  output logic                      x_mem_finished_o
);

  typedef enum logic [1:0] {S_IDLE, S_START, S_WAIT, S_RESP} state_e;

  state_e              state_q;
  vlsu_pkg::vlsu_cmd_t cmd_q;
  logic                accept;
  logic                strided;
  logic                done;
  logic [2:0]          elem_bytes;

  assign accept     = spatz_req_valid_i && spatz_req_ready_o;
  assign strided    = spatz_req_i.op inside {vlsu_pkg::VLSE, vlsu_pkg::VSSE};
  assign elem_bytes = 3'd1 << spatz_req_i.vsew;

  //////////////////////////////////////////////////
  // Decode into the command register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q.id       <= spatz_req_i.id;
      cmd_q.is_load  <= spatz_req_i.op inside {vlsu_pkg::VLE, vlsu_pkg::VLSE};
      cmd_q.vsew     <= spatz_req_i.vsew;
      cmd_q.num_elem <= spatz_req_i.vl;
      cmd_q.base     <= spatz_req_i.rs1;
      // Unit stride steps by one element
      cmd_q.stride   <= strided ? spatz_req_i.rs2 : vlsu_pkg::elen_t'(elem_bytes);
      cmd_q.vd       <= spatz_req_i.vd;
    end
  end

  // Loads finish at the VRF, stores at the memory port
  assign done = cmd_q.is_load ? vrf_done_i : mem_done_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      unique case (state_q)
        S_IDLE: begin
          if (spatz_req_valid_i) begin
            state_q <= S_START;
          end
        end
        S_START: state_q <= S_WAIT;
        S_WAIT: begin
          if (done) begin
            state_q <= S_RESP;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign spatz_req_ready_o = (state_q == S_IDLE);
  assign cmd_start_o       = (state_q == S_START);
  assign vlsu_rsp_valid_o  = (state_q == S_RESP);
  assign x_mem_finished_o  = (state_q == S_RESP);
  assign cmd_o             = cmd_q;
  assign vlsu_rsp_o        = '{id: cmd_q.id, vd: cmd_q.vd};

  //////////////////////////////////////////////////
  // Operation legality
  a_vl_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> int'(spatz_req_i.vl) <= (vlsu_pkg::VLENB >> spatz_req_i.vsew))
    else $error("vl above the register capacity for vsew");
  a_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> (spatz_req_i.rs1[1:0] & 2'(elem_bytes - 3'd1)) == '0 &&
               (!strided || (spatz_req_i.rs2[1:0] & 2'(elem_bytes - 3'd1)) == '0))
    else $error("Base or stride is not a multiple of the element size");

endmodule

`default_nettype wire

/* logic/vlsu_pkg.sv */
//////////////////////////////////////////////////
// Sized for one 32-bit memory port and 256-bit vector registers
// Elements up to 32 bits only, every operation starts at element 0
//////////////////////////////////////////////////
`default_nettype none

package vlsu_pkg;

  localparam int unsigned ELEN           = 32;
  localparam int unsigned ELENB          = ELEN / 8;
  localparam int unsigned VLENB          = 32;
  localparam int unsigned WORDS_PER_VREG = VLENB / ELENB;
  localparam int unsigned NR_VREGS       = 32;
  localparam int unsigned LOAD_DEPTH     = 4;
  localparam int unsigned ID_WIDTH       = 3;

  typedef logic [ELEN-1:0]                            elen_t;
  typedef logic [$clog2(ELENB)-1:0]                   lane_t;
  typedef logic [$clog2(VLENB):0]                     vl_t;
  typedef logic [$clog2(NR_VREGS*WORDS_PER_VREG)-1:0] vreg_addr_t;

  typedef enum logic [1:0] {EW_8, EW_16, EW_32} vsew_e;
  typedef enum logic [1:0] {VLE, VSE, VLSE, VSSE} vlsu_op_e;

  //////////////////////////////////////////////////
  // Request, command and response
  typedef struct packed {
    logic [ID_WIDTH-1:0]         id;
    vlsu_op_e                    op;
    vsew_e                       vsew;
    vl_t                         vl;
    elen_t                       rs1;
    elen_t                       rs2;
    logic [$clog2(NR_VREGS)-1:0] vd;
  } vlsu_req_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]         id;
    logic                        is_load;
    vsew_e                       vsew;
    vl_t                         num_elem;
    elen_t                       base;
    elen_t                       stride;
    logic [$clog2(NR_VREGS)-1:0] vd;
  } vlsu_cmd_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]         id;
    logic [$clog2(NR_VREGS)-1:0] vd;
  } vlsu_rsp_t;

  //////////////////////////////////////////////////
  // Memory and VRF ports
  typedef struct packed {
    elen_t            addr;
    logic             we;
    logic [ELENB-1:0] strb;
    elen_t            wdata;
    logic [1:0]       size;
  } mem_req_t;

  typedef struct packed {
    elen_t rdata;
  } mem_result_t;

  typedef struct packed {
    vreg_addr_t       waddr;
    elen_t            wdata;
    logic [ELENB-1:0] wbe;
  } vrf_wreq_t;

  // Byte mask of one element, before it is shifted into its lane
  function automatic logic [ELENB-1:0] size_mask(vsew_e vsew);
    unique case (vsew)
      EW_8:    return 4'b0001;
      EW_16:   return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

endpackage

`default_nettype wire

/* logic/vlsu_top.sv */
//////////////////////////////////////////////////
// One operation in flight, memory results return in order
//////////////////////////////////////////////////
`default_nettype none

module vlsu_top (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire vlsu_pkg::vlsu_req_t   spatz_req_i,
  input  wire logic                  spatz_req_valid_i,
  output logic                       spatz_req_ready_o,
  output logic                       vlsu_rsp_valid_o,
  output vlsu_pkg::vlsu_rsp_t        vlsu_rsp_o,
  output logic                       x_mem_valid_o,
  input  wire logic                  x_mem_ready_i,
  output vlsu_pkg::mem_req_t         x_mem_req_o,
  input  wire vlsu_pkg::mem_result_t x_mem_result_i,
  input  wire logic                  x_mem_result_valid_i,
  output logic                       x_mem_finished_o,
  output vlsu_pkg::vreg_addr_t       vrf_raddr_o,
  output logic                       vrf_re_o,
  input  wire vlsu_pkg::elen_t       vrf_rdata_i,
  input  wire logic                  vrf_rvalid_i,
  output vlsu_pkg::vreg_addr_t       vrf_waddr_o,
  output vlsu_pkg::elen_t            vrf_wdata_o,
  output logic [vlsu_pkg::ELENB-1:0] vrf_wbe_o,
  output logic                       vrf_we_o,
  input  wire logic                  vrf_wvalid_i
);

  vlsu_pkg::vlsu_cmd_t cmd;
  vlsu_pkg::vrf_wreq_t vrf_wreq;
  vlsu_pkg::elen_t     ld_data;
  vlsu_pkg::elen_t     st_wdata;
  vlsu_pkg::elen_t     st_rdata;
  vlsu_pkg::lane_t     lane_in;
  vlsu_pkg::lane_t     lane_out;
  logic cmd_start, mem_done, vrf_done;
  logic lane_push, lane_full, ld_pop, ld_empty;
  logic st_push, st_pop, st_full, st_empty;

  vlsu_op_queue i_op_queue (
    .clk_i, .reset_i, .spatz_req_i, .spatz_req_valid_i,
    .mem_done_i (mem_done),
    .vrf_done_i (vrf_done),
    .spatz_req_ready_o,
    .cmd_o      (cmd),
    .cmd_start_o(cmd_start),
    .vlsu_rsp_valid_o, .vlsu_rsp_o, .x_mem_finished_o
  );

  vlsu_mem_issue i_mem_issue (
    .clk_i, .reset_i,
    .cmd_i      (cmd),
    .cmd_start_i(cmd_start),
    .x_mem_ready_i,
    .lane_full_i(lane_full),
    .st_data_i  (st_rdata),
    .st_empty_i (st_empty),
    .x_mem_valid_o, .x_mem_req_o,
    .lane_push_o(lane_push),
    .lane_o     (lane_in),
    .st_pop_o   (st_pop),
    .mem_done_o (mem_done)
  );

  vlsu_vrf_access i_vrf_access (
    .clk_i, .reset_i,
    .cmd_i      (cmd),
    .cmd_start_i(cmd_start),
    .vrf_rdata_i, .vrf_rvalid_i, .vrf_wvalid_i,
    .ld_data_i  (ld_data),
    .ld_lane_i  (lane_out),
    .ld_empty_i (ld_empty),
    .st_full_i  (st_full),
    .vrf_raddr_o, .vrf_re_o,
    .vrf_wreq_o (vrf_wreq),
    .vrf_we_o,
    .ld_pop_o   (ld_pop),
    .st_push_o  (st_push),
    .st_data_o  (st_wdata),
    .vrf_done_o (vrf_done)
  );

  // Load data and lanes pop together, data never outnumbers lanes
  vlsu_fifo #(.T(vlsu_pkg::elen_t)) i_ld_data_fifo (
    .clk_i, .reset_i,
    .push_i(x_mem_result_valid_i), .data_i(x_mem_result_i.rdata), .pop_i(ld_pop),
    .data_o(ld_data), .empty_o(ld_empty), .full_o()
  );

  vlsu_fifo #(.T(vlsu_pkg::lane_t)) i_ld_lane_fifo (
    .clk_i, .reset_i,
    .push_i(lane_push), .data_i(lane_in), .pop_i(ld_pop),
    .data_o(lane_out), .empty_o(), .full_o(lane_full)
  );

  vlsu_fifo #(.T(vlsu_pkg::elen_t)) i_st_data_fifo (
    .clk_i, .reset_i,
    .push_i(st_push), .data_i(st_wdata), .pop_i(st_pop),
    .data_o(st_rdata), .empty_o(st_empty), .full_o(st_full)
  );

  assign vrf_waddr_o = vrf_wreq.waddr;
  assign vrf_wdata_o = vrf_wreq.wdata;
  assign vrf_wbe_o   = vrf_wreq.wbe;

endmodule

`default_nettype wire

/* logic/vlsu_vrf_access.sv */
//////////////////////////////////////////////////
// Load writes pass through one held write register
//////////////////////////////////////////////////
`default_nettype none

module vlsu_vrf_access (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire vlsu_pkg::vlsu_cmd_t cmd_i,
  input  wire logic                cmd_start_i,
  input  wire vlsu_pkg::elen_t     vrf_rdata_i,
  input  wire logic                vrf_rvalid_i,
  input  wire logic                vrf_wvalid_i,
  input  wire vlsu_pkg::elen_t     ld_data_i,
  input  wire vlsu_pkg::lane_t     ld_lane_i,
  input  wire logic                ld_empty_i,
  input  wire logic                st_full_i,
  output vlsu_pkg::vreg_addr_t     vrf_raddr_o,
  output logic                     vrf_re_o,
  output vlsu_pkg::vrf_wreq_t      vrf_wreq_o,
  output logic                     vrf_we_o,
  output logic                     ld_pop_o,
  output logic                     st_push_o,
  output vlsu_pkg::elen_t          st_data_o,
  output logic                     vrf_done_o
);

  logic                   active_q;
  vlsu_pkg::vl_t          cnt_q;
  logic                   more;
  logic [4:0]             elem_byte;
  vlsu_pkg::vreg_addr_t   word_addr;
  vlsu_pkg::lane_t        vrf_lane;
  logic [2*vlsu_pkg::ELEN-1:0] ld_dbl;
  vlsu_pkg::vrf_wreq_t    wreq_q;
  logic                   we_q;

  //////////////////////////////////////////////////
  // Element position inside vd
  assign more      = active_q && (cnt_q != cmd_i.num_elem);
  assign elem_byte = 5'(cnt_q << cmd_i.vsew);
  assign vrf_lane  = elem_byte[1:0];
  assign word_addr = vlsu_pkg::vreg_addr_t'(cmd_i.vd * vlsu_pkg::WORDS_PER_VREG)
                   + vlsu_pkg::vreg_addr_t'(elem_byte[4:2]);

  // Stores read one word per element while the FIFO has room
  assign vrf_re_o    = more && !cmd_i.is_load && !st_full_i;
  assign vrf_raddr_o = word_addr;
  assign st_push_o   = vrf_re_o && vrf_rvalid_i;
  assign st_data_o   = vrf_rdata_i >> {vrf_lane, 3'b000};

  // Loads refill the write register only once it is empty
  assign ld_pop_o = more && cmd_i.is_load && !ld_empty_i && !we_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
    end else if (cmd_start_i) begin
      active_q <= (cmd_i.num_elem != '0);
    end else if (active_q && !more && !we_q) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_start_i) begin
      cnt_q <= '0;
    end else if (ld_pop_o || st_push_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Write register
  // Rotate down by memory lane, then up to the VRF lane
  assign ld_dbl = {ld_data_i, ld_data_i} >> {ld_lane_i, 3'b000};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      we_q <= 1'b0;
    end else if (ld_pop_o) begin
      we_q <= 1'b1;
    end else if (vrf_wvalid_i) begin
      we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_pop_o) begin
      wreq_q.waddr <= word_addr;
      wreq_q.wdata <= ld_dbl[vlsu_pkg::ELEN-1:0] << {vrf_lane, 3'b000};
      wreq_q.wbe   <= vlsu_pkg::size_mask(cmd_i.vsew) << vrf_lane;
    end
  end

  assign vrf_we_o   = we_q;
  assign vrf_wreq_o = wreq_q;
  assign vrf_done_o = !active_q;

  a_write_held: assert property (@(posedge clk_i) disable iff (reset_i)
    vrf_we_o && !vrf_wvalid_i |=> vrf_we_o && $stable(vrf_wreq_o))
    else $error("VRF write dropped before it was accepted");

endmodule

`default_nettype wire

/* vlog.f */
logic/vlsu_pkg.sv
logic/vlsu_fifo.sv
logic/vlsu_op_queue.sv
logic/vlsu_mem_issue.sv
logic/vlsu_vrf_access.sv
logic/vlsu_top.sv
dv/vlsu_env_models.sv
dv/tb_vlsu.sv
